// ==== Makefile ====
# Verilator build and run for the perfect_dmem testbench

VERILATOR ?= verilator
TOP       ?= tb_perfect_dmem
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Simulation PASSED

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only when the pass message appears as a line of its own
run: compile
	@out="$$(./$(SIM_BIN) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dmem_init.hex ====
// One 128-bit line per row, line 0 first, most significant byte on the left
// Row n holds the bytes at DMEM_BASE + 16*n up to DMEM_BASE + 16*n + 15
8f3a61c40b7e92d5e41c07a85d2bf693
17c9e0b2a45d3f866e08d1fac3927b40
f2610e9d38aa7c159b4ed26304f7a8e1
5ac3b718e6029f4d21d87c5b9f40e6a3
c08e5b277d13fa69b62c0e9448f1d3a0
3e97a4f10c658be2d4b1279e86a05c3b
91fe6c08b3472de50a9d81c6e75b34f2
6b20d9e7f48a1c5387e36b0d2c95f81a
e05c3a9219b7f4c65f8d026ba13e97d4
28d1f76ac94e03b87b65ad21f0c8e459
b4a70e3d6f19c852e23b94f00d76a1c8
4c8e21f5a07d6b9319f4c0e7d53a82b6
d7392ab08e64f10c3ca57d986b01e2f4
0f6bc854e2d9304a95a1f67c7c3e0d19
a2e4917b53f08dc6c87b2e051e9a64f3
79051fe8bd2c6a4746e0b39d8ab7c520

// ==== logic/dmem_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmem_ctrl (
    input  wire logic                               clk_i,
    input  wire logic                               rstn_i,

    // Core side
    input  wire logic                               req_valid_i,
    input  dmem_pkg::dmem_req_t                     req_i,
    output logic                                    req_ready_o,
    output logic                                    rsp_valid_o,
    output dmem_pkg::dmem_rsp_t                     rsp_o,

    // Read path, driven from the live request
    output logic [dmem_pkg::DMEM_IDX_W-1:0]         rd_idx_o,
    output logic [3:0]                              fmt_offset_o,
    output dmem_pkg::mem_size_t                     fmt_size_o,
    input  dmem_pkg::line_t                         fmt_data_i,

    // Write path, driven from the captured request
    output logic [3:0]                              st_offset_o,
    output dmem_pkg::mem_size_t                     st_size_o,
    output logic                                    wr_en_o,
    output logic [dmem_pkg::DMEM_IDX_W-1:0]         wr_idx_o
);

    import dmem_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        STORE_WRITE,
        WAIT
    } state_t;

    state_t                state_q, state_d;
    logic [DMEM_CNT_W-1:0] cnt_q, cnt_d;
    logic                  accept;
    logic                  rsp_fire;
    logic                  rsp_valid_q;
    dmem_rsp_t             rsp_q;

    // Request and old data captured at acceptance
    dmem_req_t             req_q;
    line_t                 pend_data_q;

    // Line index relative to the base, wrapped inside the array
    function automatic logic [DMEM_IDX_W-1:0] line_index(input addr_t addr);
        addr_t rel;
        rel = addr - DMEM_BASE;
        return rel[DMEM_IDX_W+3:4];
    endfunction

    assign req_ready_o = (state_q == IDLE);
    assign accept      = req_valid_i && req_ready_o;

    // Counter at one means the response goes out at the next edge
    assign rsp_fire    = (state_q == WAIT) && (cnt_q == DMEM_CNT_W'(1));

    assign rd_idx_o     = line_index(req_i.addr);
    assign fmt_offset_o = req_i.addr[3:0];
    assign fmt_size_o   = req_i.size;

    assign st_offset_o  = req_q.addr[3:0];
    assign st_size_o    = req_q.size;
    assign wr_idx_o     = line_index(req_q.addr);
    assign wr_en_o      = (state_q == STORE_WRITE);

    assign rsp_valid_o  = rsp_valid_q;
    assign rsp_o        = rsp_q;

    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        case (state_q)
            IDLE: begin
                if (accept) begin
                    cnt_d   = DMEM_CNT_W'(DMEM_LATENCY);
                    // Stores spend one cycle waiting for their data
                    state_d = req_i.we ? STORE_WRITE : WAIT;
                end
            end
            STORE_WRITE: begin
                cnt_d   = cnt_q - DMEM_CNT_W'(1);
                state_d = WAIT;
            end
            WAIT: begin
                // Counter at zero is the response cycle itself
                if (cnt_q == '0) begin
                    state_d = IDLE;
                end else begin
                    cnt_d = cnt_q - DMEM_CNT_W'(1);
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q     <= IDLE;
            cnt_q       <= '0;
            rsp_valid_q <= 1'b0;
            rsp_q       <= '0;
        end else begin
            state_q     <= state_d;
            cnt_q       <= cnt_d;
            rsp_valid_q <= rsp_fire;
            if (rsp_fire) begin
                rsp_q.data <= pend_data_q;
                rsp_q.tag  <= req_q.tag;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_q       <= req_i;
            pend_data_q <= fmt_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== logic/dmem_line_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmem_line_ram (
    input  wire logic                               clk_i,

    // Read port, combinational
    input  wire logic [dmem_pkg::DMEM_IDX_W-1:0]    rd_idx_i,
    output dmem_pkg::line_t                         rd_line_o,

    // Write port, byte enables per line
    input  wire logic                               wr_en_i,
    input  wire logic [dmem_pkg::DMEM_IDX_W-1:0]    wr_idx_i,
    input  dmem_pkg::line_t                         wr_line_i,
    input  dmem_pkg::mask_t                         wr_mask_i
);

    import dmem_pkg::*;

    localparam int unsigned BYTES_PER_LINE = $bits(line_t) / 8;

    line_t mem_q [DMEM_LINES];

    // Contents come from the hex image, one line per row
    initial begin
        $readmemh(DMEM_INIT_FILE, mem_q);
    end

    assign rd_line_o = mem_q[rd_idx_i];

    // Only the enabled bytes of the addressed line change
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            for (int b = 0; b < BYTES_PER_LINE; b++) begin
                if (wr_mask_i[b]) begin
                    mem_q[wr_idx_i][8*b +: 8] <= wr_line_i[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/dmem_load_format.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmem_load_format (
    input  dmem_pkg::line_t     line_i,
    input  wire logic [3:0]     offset_i,
    input  dmem_pkg::mem_size_t size_i,
    output dmem_pkg::line_t     data_o
);

    import dmem_pkg::*;

    logic [7:0]  field_byte;
    logic [15:0] field_half;
    logic [31:0] field_word;
    logic [63:0] field_dword;

    // Low offset bits are dropped so every field is naturally aligned
    assign field_byte  = line_i[{offset_i,       3'b000}    +: 8];
    assign field_half  = line_i[{offset_i[3:1],  4'b0000}   +: 16];
    assign field_word  = line_i[{offset_i[3:2],  5'b00000}  +: 32];
    assign field_dword = line_i[{offset_i[3],    6'b000000} +: 64];

    always_comb begin
        case (size_i)
            BYTE: begin
                data_o = {{120{field_byte[7]}}, field_byte};
            end
            HALF: begin
                data_o = {{112{field_half[15]}}, field_half};
            end
            WORD: begin
                data_o = {{96{field_word[31]}}, field_word};
            end
            DWORD: begin
                data_o = {{64{field_dword[63]}}, field_dword};
            end
            BYTE_U: begin
                data_o = {120'b0, field_byte};
            end
            HALF_U: begin
                data_o = {112'b0, field_half};
            end
            WORD_U: begin
                data_o = {96'b0, field_word};
            end
            DWORD_U: begin
                data_o = {64'b0, field_dword};
            end
            LINE: begin
                data_o = line_i;
            end
            default: begin
                // Unused encodings read as zero
                data_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/dmem_pkg.sv ====
`default_nettype none

package dmem_pkg;

    // Geometry of the backing array
    localparam int unsigned DMEM_LINES = 16;
    localparam int unsigned DMEM_IDX_W = $clog2(DMEM_LINES);

    // Byte address of line 0, everything is taken relative to it
    localparam logic [31:0] DMEM_BASE = 32'h0000_1000;

    // Clock edges from acceptance to the response cycle
    localparam int unsigned DMEM_LATENCY = 3;
    localparam int unsigned DMEM_CNT_W = $clog2(DMEM_LATENCY + 1);

    // Image loaded into the array at time zero
    localparam string DMEM_INIT_FILE = "dmem_init.hex";

    typedef logic [31:0]  addr_t;
    typedef logic [127:0] line_t;
    typedef logic [15:0]  mask_t;

    // Access size, same encoding as the core's load/store unit
    typedef enum logic [3:0] {
        BYTE    = 4'd0,
        HALF    = 4'd1,
        WORD    = 4'd2,
        DWORD   = 4'd3,
        BYTE_U  = 4'd4,
        HALF_U  = 4'd5,
        WORD_U  = 4'd6,
        DWORD_U = 4'd7,
        LINE    = 4'd8
    } mem_size_t;

    // One request from the core
    typedef struct packed {
        addr_t      addr;
        mem_size_t  size;
        logic [7:0] tag;
        logic       we;
    } dmem_req_t;

    // Response back to the core, data already extended
    typedef struct packed {
        line_t      data;
        logic [7:0] tag;
    } dmem_rsp_t;

endpackage

`default_nettype wire

// ==== logic/dmem_store_format.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmem_store_format (
    input  dmem_pkg::line_t     data_i,
    input  wire logic [3:0]     offset_i,
    input  dmem_pkg::mem_size_t size_i,
    output dmem_pkg::line_t     line_o,
    output dmem_pkg::mask_t     mask_o
);

    import dmem_pkg::*;

    // Aligned byte position of each field size
    logic [6:0] shift_byte;
    logic [6:0] shift_half;
    logic [6:0] shift_word;
    logic [6:0] shift_dword;

    assign shift_byte  = {offset_i,      3'b000};
    assign shift_half  = {offset_i[3:1], 4'b0000};
    assign shift_word  = {offset_i[3:2], 5'b00000};
    assign shift_dword = {offset_i[3],   6'b000000};

    // Signed and unsigned flavours only differ on loads
    always_comb begin
        case (size_i)
            BYTE, BYTE_U: begin
                line_o = {120'b0, data_i[7:0]} << shift_byte;
                mask_o = 16'h0001 << offset_i;
            end
            HALF, HALF_U: begin
                line_o = {112'b0, data_i[15:0]} << shift_half;
                mask_o = 16'h0003 << {offset_i[3:1], 1'b0};
            end
            WORD, WORD_U: begin
                line_o = {96'b0, data_i[31:0]} << shift_word;
                mask_o = 16'h000f << {offset_i[3:2], 2'b00};
            end
            DWORD, DWORD_U: begin
                line_o = {64'b0, data_i[63:0]} << shift_dword;
                mask_o = 16'h00ff << {offset_i[3], 3'b000};
            end
            LINE: begin
                line_o = data_i;
                mask_o = '1;
            end
            default: begin
                // Nothing is written for unused encodings
                line_o = '0;
                mask_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/perfect_dmem.sv ====
`timescale 1ns/1ps
`default_nettype none

module perfect_dmem (
    input  wire logic           clk_i,
    input  wire logic           rstn_i,
    input  wire logic           req_valid_i,
    input  dmem_pkg::dmem_req_t req_i,
    output logic                req_ready_o,
    input  dmem_pkg::line_t     wr_data_i,
    output logic                rsp_valid_o,
    output dmem_pkg::dmem_rsp_t rsp_o
);

    import dmem_pkg::*;

    logic [DMEM_IDX_W-1:0] rd_idx;
    line_t                 rd_line;
    logic [3:0]            fmt_offset;
    mem_size_t             fmt_size;
    line_t                 fmt_data;

    logic [3:0]            st_offset;
    mem_size_t             st_size;
    logic                  wr_en;
    logic [DMEM_IDX_W-1:0] wr_idx;
    line_t                 wr_line;
    mask_t                 wr_mask;

    dmem_ctrl i_ctrl (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .req_ready_o  (req_ready_o),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_o        (rsp_o),
        .rd_idx_o     (rd_idx),
        .fmt_offset_o (fmt_offset),
        .fmt_size_o   (fmt_size),
        .fmt_data_i   (fmt_data),
        .st_offset_o  (st_offset),
        .st_size_o    (st_size),
        .wr_en_o      (wr_en),
        .wr_idx_o     (wr_idx)
    );

    dmem_line_ram i_ram (
        .clk_i     (clk_i),
        .rd_idx_i  (rd_idx),
        .rd_line_o (rd_line),
        .wr_en_i   (wr_en),
        .wr_idx_i  (wr_idx),
        .wr_line_i (wr_line),
        .wr_mask_i (wr_mask)
    );

    // Old contents formatted at acceptance, for loads and stores alike
    dmem_load_format i_load_fmt (
        .line_i   (rd_line),
        .offset_i (fmt_offset),
        .size_i   (fmt_size),
        .data_o   (fmt_data)
    );

    // Store data arrives a cycle late, positioned straight into the array
    dmem_store_format i_store_fmt (
        .data_i   (wr_data_i),
        .offset_i (st_offset),
        .size_i   (st_size),
        .line_o   (wr_line),
        .mask_o   (wr_mask)
    );

endmodule

`default_nettype wire

// ==== sim/dmem_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmem_properties (
    input  wire logic           clk_i,
    input  wire logic           rstn_i,
    input  wire logic           req_valid_i,
    input  dmem_pkg::dmem_req_t req_i,
    input  wire logic           req_ready_o,
    input  wire logic           rsp_valid_o,
    input  dmem_pkg::dmem_rsp_t rsp_o
);

    import dmem_pkg::*;

    logic accept;
    int   fail_cnt = 0;

    assign accept = req_valid_i && req_ready_o;

    // Ready, silent and cleared while reset is held
    reset_idle: assert property (@(posedge clk_i)
        !rstn_i |-> (req_ready_o && !rsp_valid_o && rsp_o == '0))
    else begin
        fail_cnt = fail_cnt + 1;
        $error("Memory is not idle during reset");
    end

    // Response cycle starts DMEM_LATENCY edges after acceptance, seen one edge later
    rsp_timing: assert property (@(posedge clk_i) disable iff (!rstn_i)
        rsp_valid_o == $past(accept, DMEM_LATENCY + 1))
    else begin
        fail_cnt = fail_cnt + 1;
        $error("Response pulse does not line up with an accepted request");
    end

    rsp_tag: assert property (@(posedge clk_i) disable iff (!rstn_i)
        rsp_valid_o |-> rsp_o.tag == $past(req_i.tag, DMEM_LATENCY + 1))
    else begin
        fail_cnt = fail_cnt + 1;
        $error("Response tag differs from the tag of the accepted request");
    end

    // Busy from acceptance until the response cycle ends
    ready_drop: assert property (@(posedge clk_i) disable iff (!rstn_i)
        accept |=> !req_ready_o)
    else begin
        fail_cnt = fail_cnt + 1;
        $error("Ready stayed high after a request was accepted");
    end

    busy_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (!req_ready_o && !rsp_valid_o) |=> !req_ready_o)
    else begin
        fail_cnt = fail_cnt + 1;
        $error("Ready came back before the response was given");
    end

    ready_back: assert property (@(posedge clk_i) disable iff (!rstn_i)
        rsp_valid_o |=> req_ready_o)
    else begin
        fail_cnt = fail_cnt + 1;
        $error("Ready did not return in the cycle after the response");
    end

endmodule

`default_nettype wire

// ==== sim/tb_perfect_dmem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_perfect_dmem;

    import dmem_pkg::*;

    localparam int unsigned RAND_SEED      = 32'hf0e1_8712;
    localparam int unsigned MAX_REQS       = 40;
    localparam int unsigned TIMEOUT_CYCLES = MAX_REQS * (DMEM_LATENCY + 2) + 50;
    localparam int          CONT_REQS      = 12;

    logic      clk;
    logic      rstn;
    logic      req_valid;
    dmem_req_t req;
    logic      req_ready;
    line_t     wr_data;
    logic      rsp_valid;
    dmem_rsp_t rsp;

    // Reference copy of the array and the responses still owed
    line_t       model_mem [DMEM_LINES];
    dmem_rsp_t   exp_q [$];
    logic [7:0]  next_tag;
    int          data_errors = 0;
    int unsigned cycles = 0;

    perfect_dmem i_dut (
        .clk_i       (clk),
        .rstn_i      (rstn),
        .req_valid_i (req_valid),
        .req_i       (req),
        .req_ready_o (req_ready),
        .wr_data_i   (wr_data),
        .rsp_valid_o (rsp_valid),
        .rsp_o       (rsp)
    );

    bind perfect_dmem dmem_properties i_props (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .req_ready_o (req_ready_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o)
    );

    always #50 clk = ~clk;

    function automatic int size_bytes(input mem_size_t size);
        case (size)
            BYTE, BYTE_U:   return 1;
            HALF, HALF_U:   return 2;
            WORD, WORD_U:   return 4;
            DWORD, DWORD_U: return 8;
            LINE:           return 16;
            default:        return 0;
        endcase
    endfunction

    function automatic int line_of(input addr_t addr);
        addr_t rel;
        rel = addr - DMEM_BASE;
        return int'((rel >> 4) % DMEM_LINES);
    endfunction

    // Aligned field of the old line extended to the full width
    function automatic line_t expect_load(input line_t old_line, input logic [3:0] offset,
                                          input mem_size_t size);
        int    nbytes;
        int    first;
        logic  sign;
        line_t res;
        nbytes = size_bytes(size);
        res    = '0;
        if (nbytes == 0) begin
            return res;
        end
        first = int'(offset) - (int'(offset) % nbytes);
        for (int i = 0; i < nbytes; i++) begin
            res[8*i +: 8] = old_line[8*(first + i) +: 8];
        end
        sign = (size inside {BYTE, HALF, WORD, DWORD}) && res[8*nbytes - 1];
        for (int i = nbytes; i < 16; i++) begin
            res[8*i +: 8] = {8{sign}};
        end
        return res;
    endfunction

    function automatic void apply_store(input addr_t addr, input mem_size_t size,
                                        input line_t data);
        int nbytes;
        int first;
        int idx;
        nbytes = size_bytes(size);
        idx    = line_of(addr);
        if (nbytes > 0) begin
            first = int'(addr[3:0]) - (int'(addr[3:0]) % nbytes);
            for (int i = 0; i < nbytes; i++) begin
                model_mem[idx][8*(first + i) +: 8] = data[8*i +: 8];
            end
        end
    endfunction

    // Spans twice the array so some addresses wrap
    function automatic addr_t random_addr();
        return DMEM_BASE + addr_t'($urandom % (2 * DMEM_LINES * 16));
    endfunction

    function automatic line_t random_line();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    // Called on a rising edge and returns after the response
    // With hold set it returns as soon as the request and its store data are taken
    task automatic send_request(input addr_t addr, input mem_size_t size, input logic we,
                                input line_t data, input bit hold);
        dmem_req_t new_req;
        dmem_rsp_t exp;
        new_req.addr = addr;
        new_req.size = size;
        new_req.tag  = next_tag;
        new_req.we   = we;
        next_tag     = next_tag + 8'd1;
        req_valid   <= 1'b1;
        req         <= new_req;
        @(posedge clk);
        while (!req_ready) begin
            @(posedge clk);
        end
        exp.data = expect_load(model_mem[line_of(addr)], addr[3:0], size);
        exp.tag  = new_req.tag;
        exp_q.push_back(exp);
        if (we) begin
            apply_store(addr, size, data);
            // Store data belongs to the cycle after acceptance only
            wr_data <= data;
            @(posedge clk);
            wr_data <= ~data;
        end
        if (!hold) begin
            req_valid <= 1'b0;
            do begin
                @(posedge clk);
            end while (!rsp_valid);
        end
    endtask

    initial begin
        addr_t addr;
        int    prop_errors;
        clk       = 1'b0;
        rstn      = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        wr_data   = '0;
        next_tag  = 8'h00;
        void'($urandom(RAND_SEED));
        $readmemh(DMEM_INIT_FILE, model_mem);
        repeat (3) @(posedge clk);
        rstn <= 1'b1;

        for (int s = 0; s <= 8; s++) begin
            send_request(random_addr(), mem_size_t'(4'(s)), 1'b0, '0, 1'b0);
        end

        // Each store is followed by a full-line read of the same line
        for (int s = 0; s <= 8; s++) begin
            addr = random_addr();
            send_request(addr, mem_size_t'(4'(s)), 1'b1, random_line(), 1'b0);
            send_request(addr, LINE, 1'b0, '0, 1'b0);
        end

        // Valid stays high through the whole burst
        for (int n = 0; n < CONT_REQS; n++) begin
            send_request(random_addr(), mem_size_t'(4'($urandom % 9)), ($urandom % 2) != 0,
                         random_line(), (n + 1) < CONT_REQS);
        end

        repeat (2) @(posedge clk);
        prop_errors = i_dut.i_props.fail_cnt;
        $display("Errors: %0d data, %0d property, %0d responses missing",
                 data_errors, prop_errors, exp_q.size());
        if (data_errors == 0 && prop_errors == 0 && exp_q.size() == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    always @(posedge clk) begin
        dmem_rsp_t exp;
        if (rstn && rsp_valid) begin
            if (exp_q.size() == 0) begin
                $display("Response with tag %h came with no request outstanding", rsp.tag);
                data_errors++;
            end else begin
                exp = exp_q.pop_front();
                assert (rsp.tag === exp.tag) else begin
                    $display("FAILED rsp_o.tag: got %h, expected %h", rsp.tag, exp.tag);
                    data_errors++;
                end
                assert (rsp.data === exp.data) else begin
                    $display("FAILED rsp_o.data (tag %h): got %h, expected %h",
                             exp.tag, rsp.data, exp.data);
                    data_errors++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, %0d responses still missing",
                     cycles, exp_q.size());
            $display("Simulation FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
logic/dmem_pkg.sv
logic/dmem_line_ram.sv
logic/dmem_load_format.sv
logic/dmem_store_format.sv
logic/dmem_ctrl.sv
logic/perfect_dmem.sv
sim/dmem_properties.sv
sim/tb_perfect_dmem.sv
